//--- design/minimac.sv
// Minimac top level joining the rx stage, packet RAM, tx stage and CSR control interface
module minimac (
	input  logic                  sys_clk,
	input  logic                  sys_rst,

	input  logic [13:0]           csr_a,
	input  logic                  csr_we,
	input  minimac_pkg::word_t    csr_di,
	output minimac_pkg::word_t    csr_do,
	output logic                  irq_rx,
	output logic                  irq_tx,

	input  logic                  rx_dv,
	input  logic                  rx_nibble_stb,
	input  minimac_pkg::nibble_t  rx_nibble,

	output logic                  tx_nibble_stb,
	output minimac_pkg::nibble_t  tx_nibble,
	output logic                  tx_frame
);
	import minimac_pkg::*;

	logic rx_rst;
	logic rx_valid;
	wadr_t rx_adr;
	logic rx_resetcount;
	logic rx_incrcount;
	logic rx_endframe;
	logic ram_we;
	logic [RAM_AW-1:0] ram_wadr;
	word_t ram_wdat;
	logic [RAM_AW-1:0] ram_radr;
	word_t ram_rdat;
	logic tx_valid;
	wadr_t tx_adr;
	logic [1:0] tx_bytecount;
	logic tx_next;

	assign ram_radr = tx_adr[RAM_AW-1:0];   // RAM is smaller than the address space

	minimac_ctlif #(.csr_addr(CSR_BANK)) ctlif_i (
		.sys_clk, .sys_rst,
		.csr_a, .csr_we, .csr_di, .csr_do,
		.irq_rx, .irq_tx,
		.rx_rst, .rx_valid, .rx_adr,
		.rx_resetcount, .rx_incrcount, .rx_endframe,
		.tx_valid, .tx_adr, .tx_bytecount, .tx_next
	);

	minimac_rx rx_i (
		.sys_clk, .sys_rst,
		.rx_rst, .rx_valid, .rx_adr,
		.rx_dv, .rx_nibble_stb, .rx_nibble,
		.rx_resetcount, .rx_incrcount, .rx_endframe,
		.ram_we, .ram_wadr, .ram_wdat
	);

	minimac_pktram pktram_i (
		.sys_clk,
		.we(ram_we), .wadr(ram_wadr), .wdat(ram_wdat),
		.radr(ram_radr), .rdat(ram_rdat)
	);

	minimac_tx tx_i (
		.sys_clk, .sys_rst,
		.tx_valid, .tx_bytecount, .ram_rdat,
		.tx_next, .tx_nibble_stb, .tx_nibble, .tx_frame
	);

endmodule

//--- design/minimac_ctlif.sv
// Minimac control interface with CSR decode, rx slot bookkeeping, tx pointers and interrupts
module minimac_ctlif #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  logic                sys_clk,
	input  logic                sys_rst,

	input  logic [13:0]         csr_a,
	input  logic                csr_we,
	input  minimac_pkg::word_t  csr_di,
	output minimac_pkg::word_t  csr_do,

	output logic                irq_rx,
	output logic                irq_tx,

	output logic                rx_rst,
	output logic                rx_valid,
	output minimac_pkg::wadr_t  rx_adr,
	input  logic                rx_resetcount,
	input  logic                rx_incrcount,
	input  logic                rx_endframe,

	output logic                tx_valid,
	output minimac_pkg::wadr_t  tx_adr,
	output logic [1:0]          tx_bytecount,
	input  logic                tx_next
);
	import minimac_pkg::*;

	slot_state_t slot_state [NUM_SLOTS];
	wadr_t slot_adr [NUM_SLOTS];
	bcount_t slot_count [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] slot_sel;    // One-hot, first loaded slot
	logic [NUM_SLOTS-1:0] slot_done;
	bcount_t tx_remaining;
	logic csr_selected;
	logic csr_write;
	logic [3:0] reg_idx;
	word_t csr_rdata;
	logic tx_valid_r;
	logic tx_valid_rr;

	function automatic logic [3:0] slot_reg(input int slot, input int ofs);
		return 4'(int'(REG_SLOT0_STATE) + SLOT_STRIDE * slot + ofs);
	endfunction

	assign csr_selected = csr_a[13:10] == csr_addr;
	assign csr_write = csr_selected & csr_we;
	assign reg_idx = csr_a[3:0];
	assign tx_valid = tx_remaining != '0;
	assign rx_valid = |slot_sel;

	// Slot 0 has the highest priority
	always_comb begin
		slot_sel = '0;
		rx_adr = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			slot_done[i] = slot_state[i] == SLOT_DONE;
			if (slot_state[i] == SLOT_LOADED && slot_sel == '0) begin
				slot_sel[i] = 1'b1;
				rx_adr = slot_adr[i];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			rx_rst <= 1'b1;
			tx_remaining <= '0;
			tx_adr <= '0;
			tx_bytecount <= '0;
			for (int i = 0; i < NUM_SLOTS; i++) begin
				slot_state[i] <= SLOT_FREE;
				slot_count[i] <= '0;
			end
		end else begin
			if (tx_next) begin
				tx_remaining <= tx_remaining - 11'd1;
				tx_bytecount <= tx_bytecount + 2'd1;
				if (tx_bytecount == 2'd3)
					tx_adr <= tx_adr + 30'd1;  // Word fully sent
			end
			if (csr_write && reg_idx == REG_RXRST)
				rx_rst <= csr_di[0];
			if (csr_write && reg_idx == REG_TX_ADR)
				tx_adr <= csr_di[31:2];
			if (csr_write && reg_idx == REG_TX_REM) begin
				tx_remaining <= csr_di[10:0];
				tx_bytecount <= '0;              // Restart at byte lane 0
			end
			for (int i = 0; i < NUM_SLOTS; i++) begin
				if (csr_write && reg_idx == slot_reg(i, SLOT_OFS_STATE)) begin
					slot_state[i] <= csr_di[1:0];
					slot_count[i] <= '0;
				end
				if (slot_sel[i] && rx_resetcount)
					slot_count[i] <= '0;
				if (slot_sel[i] && rx_incrcount)
					slot_count[i] <= slot_count[i] + 11'd1;
				if (slot_sel[i] && rx_endframe)
					slot_state[i] <= SLOT_DONE;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (csr_write && reg_idx == slot_reg(i, SLOT_OFS_ADR))
				slot_adr[i] <= csr_di[31:2];
		end
	end

	// Unmapped indices, including the former PHY register, read zero
	always_comb begin
		csr_rdata = '0;
		if (reg_idx == REG_RXRST)
			csr_rdata = word_t'(rx_rst);
		if (reg_idx == REG_TX_ADR)
			csr_rdata = {tx_adr, 2'b00};
		if (reg_idx == REG_TX_REM)
			csr_rdata = word_t'(tx_remaining);
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (reg_idx == slot_reg(i, SLOT_OFS_STATE))
				csr_rdata = word_t'(slot_state[i]);
			if (reg_idx == slot_reg(i, SLOT_OFS_ADR))
				csr_rdata = {slot_adr[i], 2'b00};
			if (reg_idx == slot_reg(i, SLOT_OFS_COUNT))
				csr_rdata = word_t'(slot_count[i]);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			csr_do <= '0;
		else
			csr_do <= csr_selected ? csr_rdata : '0;
	end

	// irq_tx fires two cycles after the last byte drains tx_remaining
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			irq_rx <= 1'b0;
			irq_tx <= 1'b0;
			tx_valid_r <= 1'b0;
			tx_valid_rr <= 1'b0;
		end else begin
			irq_rx <= |slot_done;
			tx_valid_r <= tx_valid;
			tx_valid_rr <= tx_valid_r;
			irq_tx <= tx_valid_rr & ~tx_valid_r;
		end
	end

endmodule

//--- design/minimac_pkg.sv
// Minimac shared package with data widths, slot states, CSR register map and tx FSM states
package minimac_pkg;

	typedef logic [31:0] word_t;     // CSR and packet RAM data word
	typedef logic [29:0] wadr_t;     // Word address
	typedef logic [10:0] bcount_t;   // Frame byte count
	typedef logic [3:0]  nibble_t;   // One nibble on the rx or tx port
	typedef logic [1:0]  slot_state_t;

	// Receive slot life cycle, written by software and advanced by the rx stage
	localparam slot_state_t SLOT_FREE   = 2'd0;
	localparam slot_state_t SLOT_LOADED = 2'd1;
	localparam slot_state_t SLOT_DONE   = 2'd2;

	localparam int RAM_AW = 9;                  // 512 words of packet RAM
	localparam logic [3:0] CSR_BANK = 4'h0;
	localparam int NUM_SLOTS = 4;

	// CSR register map, index taken from csr_a[3:0]
	localparam logic [3:0] REG_RXRST       = 4'd0;
	localparam logic [3:0] REG_SLOT0_STATE = 4'd2;
	localparam logic [3:0] REG_TX_ADR      = 4'd14;
	localparam logic [3:0] REG_TX_REM      = 4'd15;

	// Each slot owns three registers: state, address, count
	localparam int SLOT_STRIDE    = 3;
	localparam int SLOT_OFS_STATE = 0;
	localparam int SLOT_OFS_ADR   = 1;
	localparam int SLOT_OFS_COUNT = 2;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_GAP,   // RAM read latency and inter-byte spacing
		TX_LOW,
		TX_HIGH
	} tx_state_e;

endpackage

//--- design/minimac_pktram.sv
// Minimac packet RAM with one write port and one registered read port
module minimac_pktram (
	input  logic                            sys_clk,
	input  logic                            we,
	input  logic [minimac_pkg::RAM_AW-1:0]  wadr,
	input  minimac_pkg::word_t              wdat,
	input  logic [minimac_pkg::RAM_AW-1:0]  radr,
	output minimac_pkg::word_t              rdat
);
	import minimac_pkg::*;

	word_t mem [2**RAM_AW];

	always_ff @(posedge sys_clk) begin
		if (we)
			mem[wadr] <= wdat;
	end

	// Read data one cycle after radr
	always_ff @(posedge sys_clk) begin
		rdat <= mem[radr];
	end

endmodule

//--- design/minimac_rx.sv
// Minimac receive stage packing nibbles into little-endian words written to packet RAM
module minimac_rx (
	input  logic                             sys_clk,
	input  logic                             sys_rst,
	input  logic                             rx_rst,
	input  logic                             rx_valid,
	input  minimac_pkg::wadr_t               rx_adr,
	input  logic                             rx_dv,
	input  logic                             rx_nibble_stb,
	input  minimac_pkg::nibble_t             rx_nibble,
	output logic                             rx_resetcount,
	output logic                             rx_incrcount,
	output logic                             rx_endframe,
	output logic                             ram_we,
	output logic [minimac_pkg::RAM_AW-1:0]   ram_wadr,
	output minimac_pkg::word_t               ram_wdat
);
	import minimac_pkg::*;

	logic in_frame;
	logic accept;             // Frame is stored, latched at frame start
	logic hi_phase;           // Next nibble is the high half
	nibble_t lo_nib;
	word_t word_sr;
	logic [1:0] lane;         // Bytes already in word_sr
	logic [RAM_AW-1:0] woff;
	logic frame_start;
	logic nib_take;
	logic frame_end;
	logic [7:0] rx_byte;
	word_t word_next;

	assign frame_start = rx_nibble_stb & rx_dv & ~in_frame;
	assign nib_take = rx_nibble_stb & rx_dv & in_frame;
	assign frame_end = in_frame & ~rx_dv;
	assign rx_byte = {rx_nibble, lo_nib};
	assign word_next = {rx_byte, word_sr[31:8]};   // First byte ends in bits 7:0
	assign rx_resetcount = frame_start & ~rx_rst & rx_valid;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			in_frame <= 1'b0;
			accept <= 1'b0;
			hi_phase <= 1'b0;
			lane <= '0;
			rx_incrcount <= 1'b0;
			rx_endframe <= 1'b0;
			ram_we <= 1'b0;
		end else begin
			rx_incrcount <= 1'b0;
			rx_endframe <= 1'b0;
			ram_we <= 1'b0;
			if (frame_start) begin
				in_frame <= 1'b1;
				accept <= ~rx_rst & rx_valid;
				hi_phase <= 1'b1;                  // Low nibble taken here
				lane <= '0;
			end else if (nib_take) begin
				hi_phase <= ~hi_phase;
				if (hi_phase) begin
					lane <= lane + 2'd1;
					rx_incrcount <= accept;
					ram_we <= accept & (lane == 2'd3);
				end
			end else if (frame_end) begin
				in_frame <= 1'b0;
				rx_endframe <= accept;
				ram_we <= accept & (lane != 2'd0); // Partial last word
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (frame_start) begin
			lo_nib <= rx_nibble;
			woff <= '0;
		end else if (nib_take) begin
			if (!hi_phase) begin
				lo_nib <= rx_nibble;
			end else begin
				word_sr <= word_next;
				if (lane == 2'd3) begin
					ram_wadr <= rx_adr[RAM_AW-1:0] + woff;
					ram_wdat <= word_next;
					woff <= woff + 1'b1;
				end
			end
		end else if (frame_end) begin
			ram_wadr <= rx_adr[RAM_AW-1:0] + woff;
			ram_wdat <= word_sr >> {3'd4 - {1'b0, lane}, 3'b000};  // Zero-padded top
		end
	end

endmodule

//--- design/minimac_tx.sv
// Minimac transmit stage sending packet RAM bytes as nibble strobes, low nibble first
module minimac_tx (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  tx_valid,
	input  logic [1:0]            tx_bytecount,
	input  minimac_pkg::word_t    ram_rdat,
	output logic                  tx_next,
	output logic                  tx_nibble_stb,
	output minimac_pkg::nibble_t  tx_nibble,
	output logic                  tx_frame
);
	import minimac_pkg::*;

	tx_state_e state;
	logic gap_half;          // Second cycle of TX_GAP
	logic sending;           // First nibble of the frame is out
	logic [7:0] tx_byte;

	assign tx_byte = ram_rdat[{tx_bytecount, 3'b000} +: 8];
	assign tx_nibble_stb = (state == TX_LOW) | (state == TX_HIGH);
	assign tx_nibble = (state == TX_HIGH) ? tx_byte[7:4] : tx_byte[3:0];
	assign tx_next = state == TX_HIGH;
	assign tx_frame = (state == TX_LOW) | (sending & tx_valid);

	// Four cycles per byte, two of them in TX_GAP while the RAM word settles
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= TX_IDLE;
			gap_half <= 1'b0;
			sending <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: begin
					sending <= 1'b0;
					if (tx_valid)
						state <= TX_GAP;
				end
				TX_GAP: begin
					gap_half <= ~gap_half;
					if (gap_half)
						state <= tx_valid ? TX_LOW : TX_IDLE;
				end
				TX_LOW: begin
					sending <= 1'b1;
					state <= TX_HIGH;
				end
				TX_HIGH: state <= TX_GAP;
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

//--- flist.f
design/minimac_pkg.sv
design/minimac_ctlif.sv
design/minimac_rx.sv
design/minimac_tx.sv
design/minimac_pktram.sv
design/minimac.sv
sim/minimac_check.sv
sim/minimac_sva.sv
sim/minimac_tb.sv

//--- run.sh
#!/usr/bin/env bash
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal --top-module minimac_tb \
	-f flist.f -o minimac_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/minimac_sim > sim.log 2>&1
cat sim.log
grep -qx "Simulation finished: PASS" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- sim/minimac_check.sv
// Minimac checker comparing tx nibbles and framing, CSR reads and interrupts with expectations
module minimac_check (
	input logic                  sys_clk,
	input logic                  csr_rd,
	input minimac_pkg::word_t    csr_do,
	input logic                  irq_rx,
	input logic                  irq_tx,
	input logic                  tx_nibble_stb,
	input minimac_pkg::nibble_t  tx_nibble,
	input logic                  tx_frame
);
	timeunit 1ns;
	timeprecision 1ps;
	import minimac_pkg::*;

	int errors = 0;
	int irq_tx_seen = 0;
	logic rd_pend = 1'b0;        // csr_do answers one cycle after the address
	logic in_tx = 1'b0;          // Between the first and the last nibble of a frame
	nibble_t exp_nib [$];
	word_t exp_csr [$];

	task automatic expect_nibble(input nibble_t n);
		exp_nib.push_back(n);
	endtask

	task automatic expect_csr(input word_t v);
		exp_csr.push_back(v);
	endtask

	task automatic compare_irq(input logic rx_level, input int tx_pulses);
		if (irq_rx !== rx_level) begin
			$display("ERR %0t: irq_rx is %b, expected %b", $time, irq_rx, rx_level);
			errors++;
		end
		if (irq_tx_seen != tx_pulses) begin
			$display("ERR %0t: %0d irq_tx pulses, expected %0d", $time, irq_tx_seen, tx_pulses);
			errors++;
		end
	endtask

	task automatic report_leftovers();
		if (exp_nib.size() != 0 || exp_csr.size() != 0) begin
			$display("Expectations never consumed: %0d tx nibbles and %0d CSR reads",
				exp_nib.size(), exp_csr.size());
			errors++;
		end
	endtask

	always @(posedge sys_clk)
		rd_pend <= csr_rd;

	// Outputs move on the rising edge, so compare on the falling one
	always @(negedge sys_clk) begin
		nibble_t nib;
		word_t val;
		logic exp_frame;
		if (irq_tx)
			irq_tx_seen++;
		exp_frame = tx_nibble_stb | in_tx;
		if (tx_frame !== exp_frame) begin
			$display("ERR %0t: tx_frame is %b, expected %b", $time, tx_frame, exp_frame);
			errors++;
		end
		if (tx_nibble_stb && exp_nib.size() == 0) begin
			$display("A tx nibble strobe arrived at %0t with no nibble expected", $time);
			errors++;
		end else if (tx_nibble_stb) begin
			nib = exp_nib.pop_front();
			in_tx = exp_nib.size() != 0;
			if (tx_nibble !== nib) begin
				$display("ERR %0t: tx nibble %h, expected %h", $time, tx_nibble, nib);
				errors++;
			end
		end
		if (rd_pend && exp_csr.size() == 0) begin
			$display("A CSR read returned at %0t with no value expected", $time);
			errors++;
		end else if (rd_pend) begin
			val = exp_csr.pop_front();
			if (csr_do !== val) begin
				$display("ERR %0t: CSR read %h, expected %h", $time, csr_do, val);
				errors++;
			end
		end
	end

endmodule

//--- sim/minimac_sva.sv
// Minimac assertions on the tx interrupt, tx strobes and the state right after reset
module minimac_sva (
	input logic                     sys_clk,
	input logic                     sys_rst,
	input minimac_pkg::word_t       csr_do,
	input logic                     irq_rx,
	input logic                     irq_tx,
	input logic                     tx_nibble_stb,
	input logic                     tx_frame,
	input minimac_pkg::tx_state_e   tx_state
);
	timeunit 1ns;
	timeprecision 1ps;
	import minimac_pkg::*;

	irq_tx_single: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_tx |=> !irq_tx)
		else $error("irq_tx stayed high for more than one cycle");

	strobe_in_frame: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tx_nibble_stb |-> tx_frame)
		else $error("tx nibble strobe seen outside tx_frame");

	quiet_after_reset: assert property (@(posedge sys_clk)
		$fell(sys_rst) |-> !irq_rx && !irq_tx && !tx_frame && !tx_nibble_stb
			&& csr_do == '0 && tx_state == TX_IDLE)
		else $error("outputs not idle in the cycle after reset");

endmodule

bind minimac minimac_sva sva_i (
	.sys_clk, .sys_rst, .csr_do, .irq_rx, .irq_tx, .tx_nibble_stb, .tx_frame,
	.tx_state(tx_i.state)
);

//--- sim/minimac_tb.sv
// Minimac testbench sending random frames through rx, tx and the CSR bus against a byte model
module minimac_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import minimac_pkg::*;

	localparam int TIMEOUT_CYCLES = 12 * 64 * 10 * 2 + 4640;  // Frames, CSR traffic, margin

	logic sys_clk = 1'b0;
	logic sys_rst = 1'b1;
	logic [13:0] csr_a = '0;
	logic csr_we = 1'b0;
	word_t csr_di = '0;
	logic csr_rd = 1'b0;         // Marks a read for the checker
	logic rx_dv = 1'b0;
	logic rx_nibble_stb = 1'b0;
	nibble_t rx_nibble = '0;
	word_t csr_do;
	logic irq_rx;
	logic irq_tx;
	logic tx_nibble_stb;
	nibble_t tx_nibble;
	logic tx_frame;
	logic [31:0] rng = 32'd74;
	int cycles = 0;
	int tests = 0;
	int irq_tx_count = 0;
	int err_mark = 0;
	logic [7:0] last_frame [$];
	logic [7:0] frame_a [$];
	logic [7:0] frame_b [$];
	wadr_t adr_a;
	wadr_t adr_b;

	minimac minimac_i (.*);
	minimac_check check_i (.*);

	initial forever #20 sys_clk = ~sys_clk;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// Slot registers sit in groups of three after REG_SLOT0_STATE
	function automatic logic [3:0] reg_of(input int slot, input int ofs);
		return REG_SLOT0_STATE + 4'(3 * slot + ofs);
	endfunction

	task automatic csr_write(input logic [3:0] idx, input word_t val);
		@(negedge sys_clk);
		csr_a = {CSR_BANK, 6'd0, idx};
		csr_we = 1'b1;
		csr_di = val;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [3:0] idx, input word_t exp);
		@(negedge sys_clk);
		csr_a = {CSR_BANK, 6'd0, idx};
		csr_rd = 1'b1;
		check_i.expect_csr(exp);
		@(negedge sys_clk);
		csr_rd = 1'b0;
	endtask

	task automatic send_frame(input int len);
		logic [7:0] b;
		last_frame.delete();
		for (int i = 0; i < len; i++) begin
			b = 8'(next_rand());
			last_frame.push_back(b);
			@(negedge sys_clk);
			rx_dv = 1'b1;
			rx_nibble_stb = 1'b1;
			rx_nibble = b[3:0];       // Low nibble first
			@(negedge sys_clk);
			rx_nibble = b[7:4];
		end
		@(negedge sys_clk);
		rx_dv = 1'b0;
		rx_nibble_stb = 1'b0;
		repeat (3) @(negedge sys_clk);   // End pulse, slot update, irq_rx
	endtask

	task automatic transmit(input wadr_t adr);
		foreach (last_frame[i]) begin
			check_i.expect_nibble(last_frame[i][3:0]);
			check_i.expect_nibble(last_frame[i][7:4]);
		end
		irq_tx_count++;                  // One pulse per transmitted frame
		csr_write(REG_TX_ADR, {adr, 2'b00});
		csr_write(REG_TX_REM, word_t'(last_frame.size()));
		@(negedge sys_clk);
		while (!irq_tx)
			@(negedge sys_clk);
		csr_read(REG_TX_REM, '0);
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %0d %s finished with %0d errors", tests, name, check_i.errors - err_mark);
		err_mark = check_i.errors;
	endtask

	initial begin
		int len;
		repeat (3) @(negedge sys_clk);
		sys_rst = 1'b0;

		csr_read(REG_RXRST, 32'd1);
		for (int s = 0; s < NUM_SLOTS; s++)
			csr_read(reg_of(s, SLOT_OFS_STATE), word_t'(SLOT_FREE));
		csr_read(REG_TX_REM, '0);
		check_i.compare_irq(1'b0, 0);
		finish_test("reset state");

		adr_a = wadr_t'(next_rand() % 256);         // Regions cannot overlap
		adr_b = wadr_t'(288 + next_rand() % 200);
		csr_write(REG_RXRST, '0);
		csr_write(reg_of(1, SLOT_OFS_ADR), {adr_a, 2'b00});
		csr_write(reg_of(1, SLOT_OFS_STATE), word_t'(SLOT_LOADED));
		csr_write(reg_of(2, SLOT_OFS_ADR), {adr_b, 2'b00});
		csr_write(reg_of(2, SLOT_OFS_STATE), word_t'(SLOT_LOADED));
		len = 1 + int'(next_rand() % 64);
		if (len % 4 == 0)
			len = len - 1;                            // Force a partial last word
		send_frame(len);
		frame_a = last_frame;
		csr_read(reg_of(1, SLOT_OFS_STATE), word_t'(SLOT_DONE));
		csr_read(reg_of(1, SLOT_OFS_COUNT), word_t'(len));
		csr_read(reg_of(2, SLOT_OFS_STATE), word_t'(SLOT_LOADED));
		check_i.compare_irq(1'b1, 0);
		send_frame(1 + int'(next_rand() % 64));
		frame_b = last_frame;
		csr_read(reg_of(2, SLOT_OFS_STATE), word_t'(SLOT_DONE));
		csr_read(reg_of(2, SLOT_OFS_COUNT), word_t'(frame_b.size()));
		finish_test("receive into slots");

		// Slot 0 points at frame_b, so a stored frame would also spoil test 4
		csr_write(reg_of(0, SLOT_OFS_ADR), {adr_b, 2'b00});
		csr_write(reg_of(0, SLOT_OFS_STATE), word_t'(SLOT_LOADED));
		csr_write(REG_RXRST, 32'd1);
		send_frame(1 + int'(next_rand() % 64));
		csr_read(reg_of(0, SLOT_OFS_STATE), word_t'(SLOT_LOADED));
		csr_read(reg_of(0, SLOT_OFS_COUNT), '0);
		csr_write(REG_RXRST, '0);
		csr_write(reg_of(0, SLOT_OFS_STATE), word_t'(SLOT_FREE));
		send_frame(1 + int'(next_rand() % 64));
		csr_read(reg_of(0, SLOT_OFS_STATE), word_t'(SLOT_FREE));
		csr_read(reg_of(1, SLOT_OFS_COUNT), word_t'(frame_a.size()));
		csr_read(reg_of(2, SLOT_OFS_COUNT), word_t'(frame_b.size()));
		csr_read(reg_of(3, SLOT_OFS_STATE), word_t'(SLOT_FREE));
		finish_test("ignored frames");

		last_frame = frame_a;
		transmit(adr_a);
		check_i.compare_irq(1'b1, irq_tx_count);
		last_frame = frame_b;
		transmit(adr_b);
		check_i.compare_irq(1'b1, irq_tx_count);
		finish_test("transmit received frames");

		csr_write(reg_of(1, SLOT_OFS_STATE), word_t'(SLOT_LOADED));   // Reload while done
		csr_write(reg_of(2, SLOT_OFS_STATE), word_t'(SLOT_FREE));
		repeat (2) @(negedge sys_clk);
		check_i.compare_irq(1'b0, irq_tx_count);
		csr_read(reg_of(1, SLOT_OFS_STATE), word_t'(SLOT_LOADED));
		csr_read(reg_of(1, SLOT_OFS_COUNT), '0);
		finish_test("slot release");

		repeat (2) @(negedge sys_clk);
		check_i.report_leftovers();
		$display("%0d tests run, %0d errors", tests, check_i.errors);
		if (check_i.errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
